//--- files.f
hdl/s16_pkg.sv
hdl/s16_addr_decode.sv
hdl/s16_bus_access.sv
hdl/s16_read_return.sv
hdl/s16_cabinet_io.sv
hdl/s16_vblank_irq.sv
hdl/s16_main_bus.sv
tests/s16_checker.sv
tests/tb_s16_main.sv

//--- run.sh
#!/bin/sh
# Build and run the bus glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_s16_main -f files.f

./obj_dir/Vtb_s16_main | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- tests/tb_s16_main.sv
// Testbench plays the 68000; inputs change on falling edges, ROM and RAM ok come 0 to 6 clocks late
`default_nettype none

module tb_s16_main;
    timeunit 1ns;
    timeprecision 1ps;
    import s16_pkg::*;

    localparam int VBLANK_LINE = 223;
    localparam int NROWS       = 19;
    localparam int SEED        = 42812;
    localparam int WDOG_CYCLES = (NROWS + 4) * 20 + 10;  // Rows plus IRQ test and reset

    typedef struct packed {
        logic [23:0] baddr;  // 68000 byte address
        logic        rnw;
        logic        uds_n;
        logic        lds_n;
        logic [2:0]  fc;
        logic [6:0]  mask;   // Expected selects, bit 6 is I/O
    } bus_row_t;

    logic clk;
    logic rst;
    logic cpu_as_n;
    logic [ADDR_W:1] cpu_addr;
    logic cpu_rnw;
    logic cpu_uds_n;
    logic cpu_lds_n;
    logic [2:0] cpu_fc;
    logic [DATA_W-1:0] cpu_din;
    logic cpu_dtack_n;
    logic cpu_vpa_n;
    logic cpu_ipl2_n;
    logic rom_cs;
    logic [ROM_AW:1] rom_addr;
    logic [DATA_W-1:0] rom_data;
    logic rom_ok;
    logic ram_cs;
    logic vram_cs;
    logic [DATA_W-1:0] ram_data;
    logic ram_ok;
    logic char_cs;
    logic pal_cs;
    logic objram_cs;
    logic [DATA_W-1:0] char_dout;
    logic [DATA_W-1:0] pal_dout;
    logic [DATA_W-1:0] obj_dout;
    logic uds_wn;
    logic lds_wn;
    logic [8:0] vdump;
    logic hstart;
    logic [9:0] joystick1;
    logic [9:0] joystick2;
    logic [1:0] start_button;
    logic [1:0] coin_input;
    logic service;
    logic dip_test;
    logic [7:0] dipsw_a;
    logic [7:0] dipsw_b;
    logic [6:0] exp_mask;
    logic run_done;
    int errors;
    int checks;
    bus_row_t rows[NROWS];

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Device models, tag per device in the top nibble
    assign rom_data  = 16'h1000 ^ {8'h00, cpu_addr[8:1]};
    assign ram_data  = 16'h2000 ^ {8'h00, cpu_addr[8:1]};
    assign char_dout = 16'h3000 ^ {8'h00, cpu_addr[8:1]};
    assign obj_dout  = 16'h4000 ^ {8'h00, cpu_addr[8:1]};
    assign pal_dout  = 16'h5000 ^ {8'h00, cpu_addr[8:1]};

    s16_main_bus #(.VBLANK_LINE(VBLANK_LINE)) dut_i (.*);
    s16_checker #(.VBLANK_LINE(VBLANK_LINE)) chk_i (.*);

    function automatic bus_row_t mk_row(input logic [23:0] baddr, input logic rnw,
                                        input logic [1:0] strb, input logic [2:0] fc,
                                        input logic [6:0] mask);
        bus_row_t r;
        r.baddr = baddr;
        r.rnw   = rnw;
        r.uds_n = strb[1];
        r.lds_n = strb[0];
        r.fc    = fc;
        r.mask  = mask;
        return r;
    endfunction

    // One CPU bus cycle, ok raised after a random wait
    task automatic run_cycle(input bus_row_t r);
        int wait_clks;
        int cnt;
        wait_clks = $urandom_range(6, 0);
        cnt = 0;
        @(negedge clk);
        cpu_addr  <= r.baddr[23:1];
        cpu_rnw   <= r.rnw;
        cpu_uds_n <= r.uds_n;
        cpu_lds_n <= r.lds_n;
        cpu_fc    <= r.fc;
        exp_mask  <= r.mask;
        cpu_as_n  <= 1'b0;
        do begin
            @(negedge clk);
            if (rom_cs || ram_cs || vram_cs) begin
                if (cnt >= wait_clks) begin
                    rom_ok <= rom_cs;
                    ram_ok <= ram_cs | vram_cs;
                end
                cnt++;
            end
        end while (cpu_dtack_n && cpu_vpa_n);
        cpu_as_n  <= 1'b1;  // End of cycle
        rom_ok    <= 1'b0;
        ram_ok    <= 1'b0;
        cpu_rnw   <= 1'b1;
        cpu_uds_n <= 1'b1;
        cpu_lds_n <= 1'b1;
        cpu_fc    <= 3'd0;
        repeat (2) @(negedge clk);  // Selects drop
    endtask

    task automatic pulse_hstart(input logic [8:0] line);
        @(negedge clk);
        vdump  <= line;
        hstart <= 1'b1;
        @(negedge clk);
        hstart <= 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        void'($urandom(SEED));
        rst          = 1'b1;
        cpu_as_n     = 1'b1;
        cpu_addr     = '0;
        cpu_rnw      = 1'b1;
        cpu_uds_n    = 1'b1;
        cpu_lds_n    = 1'b1;
        cpu_fc       = 3'd0;
        rom_ok       = 1'b0;
        ram_ok       = 1'b0;
        vdump        = 9'd0;
        hstart       = 1'b0;
        joystick1    = 10'h2a5;
        joystick2    = 10'h15a;
        start_button = 2'b10;
        coin_input   = 2'b01;
        service      = 1'b1;
        dip_test     = 1'b0;
        dipsw_a      = 8'hc3;
        dipsw_b      = 8'h5e;
        exp_mask     = 7'h00;
        run_done     = 1'b0;
        rows[0]  = mk_row(24'h012344, 1'b1, 2'b00, 3'd5, 7'h01);  // ROM
        rows[1]  = mk_row(24'h03fffe, 1'b1, 2'b00, 3'd6, 7'h01);
        rows[2]  = mk_row(24'h400106, 1'b1, 2'b00, 3'd5, 7'h02);  // VRAM
        rows[3]  = mk_row(24'h410a20, 1'b1, 2'b00, 3'd5, 7'h04);  // Text RAM
        rows[4]  = mk_row(24'h440052, 1'b1, 2'b00, 3'd5, 7'h08);  // Sprites
        rows[5]  = mk_row(24'h840ffe, 1'b1, 2'b00, 3'd5, 7'h10);  // Palette
        rows[6]  = mk_row(24'hc40000, 1'b1, 2'b00, 3'd5, 7'h40);  // I/O words 0 to 3
        rows[7]  = mk_row(24'hc40002, 1'b1, 2'b00, 3'd5, 7'h40);
        rows[8]  = mk_row(24'hc40004, 1'b1, 2'b00, 3'd5, 7'h40);
        rows[9]  = mk_row(24'hc40006, 1'b1, 2'b00, 3'd5, 7'h40);
        rows[10] = mk_row(24'hc60000, 1'b0, 2'b00, 3'd5, 7'h00);  // Watchdog kick
        rows[11] = mk_row(24'hc70010, 1'b1, 2'b00, 3'd5, 7'h20);  // Work RAM
        rows[12] = mk_row(24'h420000, 1'b1, 2'b00, 3'd5, 7'h00);  // Unmapped
        rows[13] = mk_row(24'h8a0000, 1'b1, 2'b00, 3'd5, 7'h00);
        rows[14] = mk_row(24'hfffff8, 1'b1, 2'b11, 3'd7, 7'h00);  // IACK, nothing pending
        rows[15] = mk_row(24'h000100, 1'b0, 2'b01, 3'd5, 7'h01);  // ROM write, upper byte
        rows[16] = mk_row(24'hc70020, 1'b0, 2'b10, 3'd5, 7'h20);  // RAM write, lower byte
        rows[17] = mk_row(24'h400200, 1'b0, 2'b00, 3'd5, 7'h02);
        rows[18] = mk_row(24'hc7fffe, 1'b1, 2'b00, 3'd5, 7'h20);
        repeat (10) @(negedge clk);
        rst <= 1'b0;
        repeat (2) @(negedge clk);
        for (int i = 0; i < NROWS; i++) begin
            run_cycle(rows[i]);
        end
        pulse_hstart(9'd100);  // Not the blanking line
        pulse_hstart(9'(VBLANK_LINE));
        run_cycle(mk_row(24'hfffff8, 1'b1, 2'b11, 3'd7, 7'h00));
        run_done <= 1'b1;
        repeat (2) @(negedge clk);
        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Run limit from the table length
    initial begin
        #(WDOG_CYCLES * 40);
        $display("Timeout: a bus cycle was never acknowledged");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/s16_checker.sv
// Bus checker; samples on falling edges and expects the DUT inputs to change only on falling edges
`default_nettype none

module s16_checker #(
    parameter int VBLANK_LINE = 223
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        cpu_as_n,
    input  wire logic [s16_pkg::ADDR_W:1]    cpu_addr,
    input  wire logic                        cpu_rnw,
    input  wire logic                        cpu_uds_n,
    input  wire logic                        cpu_lds_n,
    input  wire logic [2:0]                  cpu_fc,
    input  wire logic [s16_pkg::DATA_W-1:0]  cpu_din,
    input  wire logic                        cpu_dtack_n,
    input  wire logic                        cpu_vpa_n,
    input  wire logic                        cpu_ipl2_n,
    input  wire logic                        rom_cs,
    input  wire logic [s16_pkg::ROM_AW:1]    rom_addr,
    input  wire logic                        rom_ok,
    input  wire logic                        ram_cs,
    input  wire logic                        vram_cs,
    input  wire logic                        ram_ok,
    input  wire logic                        char_cs,
    input  wire logic                        pal_cs,
    input  wire logic                        objram_cs,
    input  wire logic                        uds_wn,
    input  wire logic                        lds_wn,
    input  wire logic [8:0]                  vdump,
    input  wire logic                        hstart,
    input  wire logic [9:0]                  joystick1,
    input  wire logic [9:0]                  joystick2,
    input  wire logic [1:0]                  start_button,
    input  wire logic [1:0]                  coin_input,
    input  wire logic                        service,
    input  wire logic                        dip_test,
    input  wire logic [7:0]                  dipsw_a,
    input  wire logic [7:0]                  dipsw_b,
    input  wire logic [6:0]                  exp_mask,  // io, ram, pal, obj, char, vram, rom
    input  wire logic                        run_done,
    output int                               errors,
    output int                               checks
);
    timeunit 1ns;
    timeprecision 1ps;
    import s16_pkg::*;

    int   err_n       = 0;
    int   chk_n       = 0;
    int   lat         = 0;     // Clocks with as_n low
    int   ok_at       = -1;    // Sample where ok was first seen
    logic acked       = 1'b0;
    logic exp_ipl     = 1'b1;  // Interrupt line model
    logic prev_hstart = 1'b0;
    logic irq_seen    = 1'b0;
    logic final_done  = 1'b0;

    assign errors = err_n;
    assign checks = chk_n;

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        chk_n++;
        if (exp_v !== act_v) begin
            err_n++;
            $display("FAIL %0t %s expected %0h got %0h", $time, name, exp_v, act_v);
        end
    endtask

    // Device tags XOR the low address byte, I/O words per cabinet layout
    function automatic logic [DATA_W-1:0] expected_word(input logic [6:0] mask,
                                                        input logic [ADDR_W:1] a);
        logic [DATA_W-1:0] lo;
        lo = {8'h00, a[8:1]};
        if (mask[0]) return 16'h1000 ^ lo;
        if (mask[1] || mask[5]) return 16'h2000 ^ lo;  // Shared RAM port
        if (mask[2]) return 16'h3000 ^ lo;
        if (mask[3]) return 16'h4000 ^ lo;
        if (mask[4]) return 16'h5000 ^ lo;
        if (mask[6]) begin
            case (a[2:1])
                2'd0:    return {10'h3ff, coin_input, start_button, dip_test, service};
                2'd1:    return {6'h3f, joystick1};
                2'd2:    return {6'h3f, joystick2};
                default: return {dipsw_a, dipsw_b};
            endcase
        end
        return OPEN_BUS;
    endfunction

    task automatic check_ack();
        if (cpu_fc == 3'd7) begin
            check_val("cpu_vpa_n", 32'h0, 32'(cpu_vpa_n));
            check_val("cpu_dtack_n", 32'h1, 32'(cpu_dtack_n));
        end else begin
            check_val("cpu_dtack_n", 32'h0, 32'(cpu_dtack_n));
            check_val("cpu_vpa_n", 32'h1, 32'(cpu_vpa_n));
        end
        if (exp_mask[0] || exp_mask[1] || exp_mask[5]) begin
            if (ok_at < 0) begin
                err_n++;
                $display("ERROR at %0t: dtack came before the memory reported ok", $time);
            end else begin
                check_val("cpu_dtack_n latency", 32'(ok_at), 32'(lat));  // One clock after ok
            end
        end else begin
            check_val("cpu_dtack_n latency", 32'd3, 32'(lat));
        end
        if (cpu_rnw) check_val("cpu_din", 32'(expected_word(exp_mask, cpu_addr)), 32'(cpu_din));
        if (exp_mask[0]) check_val("rom_addr", 32'(cpu_addr[ROM_AW:1]), 32'(rom_addr));
    endtask

    always @(negedge clk) begin
        if (rst) begin
            check_val("chip selects", 32'h0,
                      32'({ram_cs, pal_cs, objram_cs, char_cs, vram_cs, rom_cs}));
            check_val("cpu_dtack_n", 32'h1, 32'(cpu_dtack_n));
            check_val("cpu_vpa_n", 32'h1, 32'(cpu_vpa_n));
            check_val("cpu_ipl2_n", 32'h1, 32'(cpu_ipl2_n));
            check_val("cpu_din", 32'(OPEN_BUS), 32'(cpu_din));
            lat         = 0;
            ok_at       = -1;
            acked       = 1'b0;
            exp_ipl     = 1'b1;
            prev_hstart = 1'b0;
        end else begin
            // Ack wins over a new request
            if (!cpu_as_n && cpu_fc == 3'd7) exp_ipl = 1'b1;
            else if (hstart && !prev_hstart && vdump == 9'(VBLANK_LINE)) exp_ipl = 1'b0;
            prev_hstart = hstart;
            check_val("cpu_ipl2_n", 32'(exp_ipl), 32'(cpu_ipl2_n));
            if (!cpu_ipl2_n) irq_seen = 1'b1;
            check_val("uds_wn", 32'(cpu_rnw | cpu_uds_n), 32'(uds_wn));
            check_val("lds_wn", 32'(cpu_rnw | cpu_lds_n), 32'(lds_wn));
            if (cpu_as_n) begin
                lat   = 0;  // Bus idle
                ok_at = -1;
                acked = 1'b0;
            end else if (!acked) begin
                lat++;
                if ((rom_ok || ram_ok) && ok_at < 0) ok_at = lat;
                if (lat >= 2) begin
                    check_val("chip selects", 32'(exp_mask[5:0]),
                              32'({ram_cs, pal_cs, objram_cs, char_cs, vram_cs, rom_cs}));
                end
                if (!cpu_dtack_n || !cpu_vpa_n) begin
                    acked = 1'b1;
                    check_ack();
                end
            end
            if (run_done && !final_done) begin
                final_done = 1'b1;
                if (!irq_seen) begin
                    err_n++;
                    $display("ERROR: the vertical blank interrupt was never raised");
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/s16_main_bus.sv
// Main CPU bus glue; cpu_addr is A23..A1, strobes must stay stable until dtack or vpa falls
`default_nettype none

module s16_main_bus #(
    parameter int VBLANK_LINE = 223
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    // CPU
    input  wire logic                        cpu_as_n,
    input  wire logic [s16_pkg::ADDR_W:1]    cpu_addr,
    input  wire logic                        cpu_rnw,
    input  wire logic                        cpu_uds_n,
    input  wire logic                        cpu_lds_n,
    input  wire logic [2:0]                  cpu_fc,
    output logic      [s16_pkg::DATA_W-1:0]  cpu_din,
    output logic                             cpu_dtack_n,
    output logic                             cpu_vpa_n,
    output logic                             cpu_ipl2_n,
    // ROM
    output logic                             rom_cs,
    output logic      [s16_pkg::ROM_AW:1]    rom_addr,
    input  wire logic [s16_pkg::DATA_W-1:0]  rom_data,
    input  wire logic                        rom_ok,
    // Work RAM and VRAM
    output logic                             ram_cs,
    output logic                             vram_cs,
    input  wire logic [s16_pkg::DATA_W-1:0]  ram_data,
    input  wire logic                        ram_ok,
    // Video chips
    output logic                             char_cs,
    output logic                             pal_cs,
    output logic                             objram_cs,
    input  wire logic [s16_pkg::DATA_W-1:0]  char_dout,
    input  wire logic [s16_pkg::DATA_W-1:0]  pal_dout,
    input  wire logic [s16_pkg::DATA_W-1:0]  obj_dout,
    output logic                             uds_wn,
    output logic                             lds_wn,
    // Video timing
    input  wire logic [8:0]                  vdump,
    input  wire logic                        hstart,
    // Cabinet
    input  wire logic [9:0]                  joystick1,
    input  wire logic [9:0]                  joystick2,
    input  wire logic [1:0]                  start_button,
    input  wire logic [1:0]                  coin_input,
    input  wire logic                        service,
    input  wire logic                        dip_test,
    input  wire logic [7:0]                  dipsw_a,
    input  wire logic [7:0]                  dipsw_b
);
    import s16_pkg::*;

    s16_region_e       region;       // Decoded target
    s16_region_e       done_region;  // Target of the finishing cycle
    logic              access_done;
    logic              io_sel;
    logic [DATA_W-1:0] io_word;

    // Write strobes only on write cycles
    assign uds_wn = cpu_rnw | cpu_uds_n;
    assign lds_wn = cpu_rnw | cpu_lds_n;

    s16_addr_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .as_n     (cpu_as_n),
        .addr     (cpu_addr),
        .fc       (cpu_fc),
        .region   (region),
        .rom_addr (rom_addr)
    );

    s16_bus_access u_access (
        .clk         (clk),
        .rst         (rst),
        .as_n        (cpu_as_n),
        .region      (region),
        .rom_ok      (rom_ok),
        .ram_ok      (ram_ok),
        .rom_cs      (rom_cs),
        .ram_cs      (ram_cs),
        .vram_cs     (vram_cs),
        .char_cs     (char_cs),
        .pal_cs      (pal_cs),
        .objram_cs   (objram_cs),
        .io_sel      (io_sel),
        .access_done (access_done),
        .done_region (done_region)
    );

    // Selected word only matters while the I/O select is up
    s16_cabinet_io u_io (
        .word_sel     (io_sel ? cpu_addr[2:1] : 2'd0),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .io_word      (io_word)
    );

    s16_read_return u_return (
        .clk         (clk),
        .rst         (rst),
        .as_n        (cpu_as_n),
        .access_done (access_done),
        .done_region (done_region),
        .rom_data    (rom_data),
        .ram_data    (ram_data),
        .char_dout   (char_dout),
        .pal_dout    (pal_dout),
        .obj_dout    (obj_dout),
        .io_word     (io_word),
        .din         (cpu_din),
        .dtack_n     (cpu_dtack_n),
        .vpa_n       (cpu_vpa_n)
    );

    s16_vblank_irq #(
        .VBLANK_LINE (VBLANK_LINE)
    ) u_irq (
        .clk    (clk),
        .rst    (rst),
        .vdump  (vdump),
        .hstart (hstart),
        .as_n   (cpu_as_n),
        .fc     (cpu_fc),
        .ipl2_n (cpu_ipl2_n)
    );

endmodule

`default_nettype wire

//--- hdl/s16_vblank_irq.sv
// Level 4 VBLANK interrupt; set on the hstart edge of VBLANK_LINE, any CPU space cycle clears it
`default_nettype none

module s16_vblank_irq #(
    parameter int VBLANK_LINE = 223  // First blanked line
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [8:0]  vdump,
    input  wire logic        hstart,
    input  wire logic        as_n,
    input  wire logic [2:0]  fc,
    output logic             ipl2_n
);

    logic last_hstart;  // Previous hstart for edge detection
    logic line_start;   // Rising hstart
    logic inta;         // Interrupt acknowledge in progress

    assign line_start = hstart & ~last_hstart;
    assign inta       = ~as_n & (fc == 3'd7);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_hstart <= 1'b0;
            ipl2_n      <= 1'b1;
        end else begin
            last_hstart <= hstart;
            if (inta) begin
                ipl2_n <= 1'b1;  // Ack beats a new request
            end else if (line_start && vdump == 9'(VBLANK_LINE)) begin
                ipl2_n <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/s16_cabinet_io.sv
// Cabinet input words, all inputs active low; word_sel is A2..A1 and the block is purely combinational
`default_nettype none

module s16_cabinet_io (
    input  wire logic [1:0]                  word_sel,
    input  wire logic [9:0]                  joystick1,
    input  wire logic [9:0]                  joystick2,
    input  wire logic [1:0]                  start_button,
    input  wire logic [1:0]                  coin_input,
    input  wire logic                        service,
    input  wire logic                        dip_test,
    input  wire logic [7:0]                  dipsw_a,
    input  wire logic [7:0]                  dipsw_b,
    output logic      [s16_pkg::DATA_W-1:0]  io_word
);

    logic [s16_pkg::DATA_W-1:0] sys_word;  // Coins, starts, test, service
    logic [s16_pkg::DATA_W-1:0] p1_word;
    logic [s16_pkg::DATA_W-1:0] p2_word;
    logic [s16_pkg::DATA_W-1:0] dip_word;

    // Unused lines float high, like the pull-ups on the board
    assign sys_word = {
        10'h3ff,
        coin_input,     // Bits 5..4
        start_button,   // Bits 3..2
        dip_test,       // Bit 1
        service         // Bit 0
    };

    assign p1_word = {6'h3f, joystick1};
    assign p2_word = {6'h3f, joystick2};

    // Both DIP banks on one word
    assign dip_word = {dipsw_a, dipsw_b};

    always_comb begin
        case (word_sel)
            2'd0:    io_word = sys_word;
            2'd1:    io_word = p1_word;
            2'd2:    io_word = p2_word;
            default: io_word = dip_word;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/s16_read_return.sv
// Read word latch and acknowledge; din holds until the next completed cycle, writes ack the same way
`default_nettype none

module s16_read_return (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        as_n,
    input  wire logic                        access_done,
    input  wire s16_pkg::s16_region_e        done_region,
    input  wire logic [s16_pkg::DATA_W-1:0]  rom_data,
    input  wire logic [s16_pkg::DATA_W-1:0]  ram_data,
    input  wire logic [s16_pkg::DATA_W-1:0]  char_dout,
    input  wire logic [s16_pkg::DATA_W-1:0]  pal_dout,
    input  wire logic [s16_pkg::DATA_W-1:0]  obj_dout,
    input  wire logic [s16_pkg::DATA_W-1:0]  io_word,
    output logic      [s16_pkg::DATA_W-1:0]  din,
    output logic                             dtack_n,
    output logic                             vpa_n
);
    import s16_pkg::*;

    logic [DATA_W-1:0] rd_word;  // Data of the finished target

    always_comb begin
        case (done_region)
            REG_RAM, REG_VRAM: rd_word = ram_data;  // Shared SDRAM port
            REG_ROM:           rd_word = rom_data;
            REG_CHAR:          rd_word = char_dout;
            REG_PAL:           rd_word = pal_dout;
            REG_OBJ:           rd_word = obj_dout;
            REG_IO:            rd_word = io_word;
            default:           rd_word = OPEN_BUS;  // Unmapped, watchdog, IACK
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            din     <= OPEN_BUS;
            dtack_n <= 1'b1;
            vpa_n   <= 1'b1;
        end else if (as_n) begin
            dtack_n <= 1'b1;  // CPU ended the cycle
            vpa_n   <= 1'b1;
        end else if (access_done) begin
            din <= rd_word;
            // Autovector answer for the interrupt cycle
            if (done_region == REG_IACK) begin
                vpa_n <= 1'b0;
            end else begin
                dtack_n <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/s16_bus_access.sv
// Chip select stage; ROM and RAM wait on ok without limit, all other targets finish in one clock
`default_nettype none

module s16_bus_access (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                as_n,
    input  wire s16_pkg::s16_region_e region,
    input  wire logic                rom_ok,
    input  wire logic                ram_ok,
    output logic                     rom_cs,
    output logic                     ram_cs,
    output logic                     vram_cs,
    output logic                     char_cs,
    output logic                     pal_cs,
    output logic                     objram_cs,
    output logic                     io_sel,
    output logic                     access_done,
    output s16_pkg::s16_region_e     done_region
);
    import s16_pkg::*;

    logic act_q;     // Strobe low, aligned with region
    logic misc_sel;  // Watchdog, unmapped and IACK share one select
    logic done_q;    // Current cycle already completed
    logic slow_rdy;  // Selected memory reports ok
    logic fast_rdy;  // Fixed-latency target selected

    // Unmapped space decodes to REG_NONE like the idle bus,
    // so the delayed strobe tells the two apart
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            act_q       <= 1'b0;
            rom_cs      <= 1'b0;
            ram_cs      <= 1'b0;
            vram_cs     <= 1'b0;
            char_cs     <= 1'b0;
            pal_cs      <= 1'b0;
            objram_cs   <= 1'b0;
            io_sel      <= 1'b0;
            misc_sel    <= 1'b0;
            done_region <= REG_NONE;
        end else begin
            act_q       <= ~as_n;
            rom_cs      <= (region == REG_ROM);
            ram_cs      <= (region == REG_RAM);
            vram_cs     <= (region == REG_VRAM);
            char_cs     <= (region == REG_CHAR);
            pal_cs      <= (region == REG_PAL);
            objram_cs   <= (region == REG_OBJ);
            io_sel      <= (region == REG_IO);
            misc_sel    <= act_q && (region == REG_NONE || region == REG_WDOG ||
                                     region == REG_IACK);
            done_region <= region;  // Tracks the selects
        end
    end

    assign slow_rdy = (rom_cs & rom_ok) | ((ram_cs | vram_cs) & ram_ok);
    assign fast_rdy = char_cs | pal_cs | objram_cs | io_sel | misc_sel;

    // One pulse per bus cycle
    assign access_done = ~done_q & (slow_rdy | fast_rdy);

    // Cleared once the strobe is gone, selects still high then
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_q <= 1'b0;
        end else if (!act_q) begin
            done_q <= 1'b0;
        end else if (access_done) begin
            done_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/s16_addr_decode.sv
// Memory map decoder; addr holds byte address bits 23..1, region follows as_n by one clock
`default_nettype none

module s16_addr_decode (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       as_n,
    input  wire logic [s16_pkg::ADDR_W:1]   addr,
    input  wire logic [2:0]                 fc,
    output s16_pkg::s16_region_e            region,
    output logic      [s16_pkg::ROM_AW:1]   rom_addr
);
    import s16_pkg::*;

    s16_region_e map_region;   // Region of the address on the bus now
    logic        is_iack;      // CPU space cycle

    assign is_iack = (fc == 3'd7);

    // Top two bits pick the 4 MB block, A18..A16 the device inside it
    always_comb begin
        map_region = REG_NONE;
        if (is_iack) begin
            map_region = REG_IACK;  // Address is the level, not a device
        end else begin
            case (addr[23:22])
                2'd0: map_region = REG_ROM;   // Whole block is ROM
                2'd1: begin
                    case (addr[18:16])
                        3'd0:    map_region = REG_VRAM;
                        3'd1:    map_region = REG_CHAR;
                        3'd4:    map_region = REG_OBJ;
                        default: map_region = REG_NONE;
                    endcase
                end
                2'd2: begin
                    if (addr[18:16] == 3'd4) begin
                        map_region = REG_PAL;
                    end
                end
                default: begin
                    case (addr[18:16])
                        3'd4:    map_region = REG_IO;
                        3'd6:    map_region = REG_WDOG;
                        3'd7:    map_region = REG_RAM;
                        default: map_region = REG_NONE;
                    endcase
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            region   <= REG_NONE;
            rom_addr <= '0;
        end else if (!as_n) begin
            region <= map_region;
            if (map_region == REG_ROM) begin
                rom_addr <= addr[ROM_AW:1];  // Held between ROM cycles
            end
        end else begin
            region <= REG_NONE;  // Strobe released
        end
    end

endmodule

`default_nettype wire

//--- hdl/s16_pkg.sv
// Shared bus widths and region codes; address vectors are indexed as 68000 byte address bits
`default_nettype none

package s16_pkg;

    // CPU bus, word address A23..A1
    localparam int ADDR_W = 23;
    localparam int DATA_W = 16;

    // ROM word address A17..A1, 256 kB of program space
    localparam int ROM_AW = 17;

    // Pulled-up data bus, seen on unmapped reads
    localparam logic [DATA_W-1:0] OPEN_BUS = {DATA_W{1'b1}};

    // Target of the current bus cycle
    // REG_NONE doubles as the idle code between cycles
    typedef enum logic [3:0] {
        REG_NONE = 4'd0,  // Unmapped or idle
        REG_ROM  = 4'd1,  // Program ROM, 00-03
        REG_VRAM = 4'd2,  // Tile RAM, 40
        REG_CHAR = 4'd3,  // Text layer RAM, 41
        REG_OBJ  = 4'd4,  // Sprite RAM, 44
        REG_PAL  = 4'd5,  // Palette, 84
        REG_IO   = 4'd6,  // Cabinet inputs, c4
        REG_WDOG = 4'd7,  // Watchdog, write only
        REG_RAM  = 4'd8,  // Work RAM, c7
        REG_IACK = 4'd9   // Interrupt acknowledge, FC = 7
    } s16_region_e;

endpackage

`default_nettype wire
